// ==== all.f ====
design/mm_pkg.sv
design/stream_pkg.sv
design/stream_fifo.sv
design/client_arbiter.sv
design/reduce_table.sv
design/mult_mod_pipe.sv
design/mult_mod_top.sv
tb/mult_mod_asserts.sv
tb/mult_mod_checker.sv
tb/tb_mult_mod.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_mult_mod
FILELIST   := all.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "Simulation ended without a verdict"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/tb_mult_mod.sv ====
`timescale 1ns/100ps

module tb_mult_mod
  import mm_pkg::*;
  import stream_pkg::*;
();

  localparam int          NUM_OPS  = 400;
  localparam logic [31:0] SEED     = 32'h7e7a2577;
  localparam int          RDY_PCT  = 75;
  localparam int          CLK_PER  = 8;
  localparam int          DRV_DLY  = 1;
  localparam int          RST_CYC  = 5;
  localparam int          MAX_CYC  = TBL_DEPTH + NUM_CLIENTS * NUM_OPS * 16;
  // Ops per client in each phase, edge phase covers all 25 pairs
  localparam int          NUM_EDGE = 25;
  localparam int          NUM_SOLO = 75;
  localparam int          NUM_FAIR = 100;
  localparam int          NUM_MIX  = NUM_OPS - NUM_EDGE - NUM_SOLO - NUM_FAIR;
  localparam int          MODE_EDGE  = 0;
  localparam int          MODE_RAND  = 1;
  localparam int          MODE_FLOOD = 2;

  logic                   i_clk;
  logic                   i_rst;
  logic [NUM_CLIENTS-1:0] i_req_val;
  op_t                    i_req [NUM_CLIENTS];
  logic [NUM_CLIENTS-1:0] o_req_rdy;
  logic [NUM_CLIENTS-1:0] o_rsp_val;
  res_t                   o_rsp [NUM_CLIENTS];
  logic [NUM_CLIENTS-1:0] i_rsp_rdy;
  logic                   fair_win;
  logic                   rsp_all_rdy;
  logic [31:0]            lfsr_state;
  int                     err_cnt;
  int                     chk_cnt;
  int                     pend_cnt;
  int                     cyc = 0;

  mult_mod_top UUT (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_req_val (i_req_val),
    .i_req     (i_req),
    .o_req_rdy (o_req_rdy),
    .o_rsp_val (o_rsp_val),
    .o_rsp     (o_rsp),
    .i_rsp_rdy (i_rsp_rdy)
  );

  mult_mod_checker u_checker (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_req_val  (i_req_val),
    .i_req      (i_req),
    .i_req_rdy  (o_req_rdy),
    .i_rsp_val  (o_rsp_val),
    .i_rsp      (o_rsp),
    .i_rsp_rdy  (i_rsp_rdy),
    .i_fair_win (fair_win),
    .o_err_cnt  (err_cnt),
    .o_chk_cnt  (chk_cnt),
    .o_pend_cnt (pend_cnt)
  );

  bind mult_mod_pipe mult_mod_asserts u_asserts (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_in_rdy    (o_rdy),
    .i_out_val   (o_val),
    .i_out_rsp   (o_rsp),
    .i_out_rdy   (i_rdy),
    .i_tbl_built (tbl_built)
  );

  initial begin
    i_clk = 1'b0;
    forever begin
      #(CLK_PER / 2) i_clk = ~i_clk;
    end
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [DAT_BITS-1:0] edge_value(input int idx);
    case (idx)
      0: return '0;
      1: return DAT_BITS'(1);
      2: return DAT_BITS'(MODULUS - 1);
      3: return DAT_BITS'(MODULUS);
      default: return '1;
    endcase
  endfunction

  // Mostly random, now and then an edge value
  function automatic logic [DAT_BITS-1:0] rand_operand();
    if (rand_bits(3) == 0) return edge_value(int'(rand_bits(3)) % 5);
    return DAT_BITS'(rand_bits(DAT_BITS));
  endfunction

  // Entered and left 1 ns after a rising edge
  task automatic send_op(input int c, input op_t op, input bit gaps);
    int   idle;
    logic acc;
    if (gaps) begin
      idle = int'(rand_bits(2));
      i_req_val[c] = 1'b0;
      repeat (idle) begin
        @(posedge i_clk);
        #DRV_DLY;
      end
    end
    i_req_val[c] = 1'b1;
    i_req[c]     = op;
    acc = 1'b0;
    while (!acc) begin
      // FIFO ready is settled by the falling edge
      @(negedge i_clk);
      acc = o_req_rdy[c];
      @(posedge i_clk);
      #DRV_DLY;
    end
  endtask

  task automatic run_client(input int c, input int n, input int mode);
    op_t op;
    for (int k = 0; k < n; k++) begin
      if (mode == MODE_EDGE) begin
        op.a = edge_value((c == 0) ? k / 5 : k % 5);
        op.b = edge_value((c == 0) ? k % 5 : k / 5);
      end else begin
        op.a = rand_operand();
        op.b = rand_operand();
      end
      send_op(c, op, mode == MODE_RAND);
    end
    i_req_val[c] = 1'b0;
  endtask

  task automatic print_report(input bit timed_out);
    int asrt_cnt;
    asrt_cnt = UUT.u_pipe.u_asserts.fail_cnt;
    $display("Checked %0d results, %0d errors, %0d assertion failures, %0d missing responses",
             chk_cnt, err_cnt, asrt_cnt, pend_cnt);
    if (!timed_out && err_cnt == 0 && asrt_cnt == 0 && pend_cnt == 0 &&
        chk_cnt == NUM_CLIENTS * NUM_OPS) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  // Response back-pressure, roughly three cycles in four ready
  always @(posedge i_clk) begin
    #DRV_DLY;
    for (int c = 0; c < NUM_CLIENTS; c++) begin
      i_rsp_rdy[c] = rsp_all_rdy || (rand_bits(8) < (RDY_PCT * 256) / 100);
    end
  end

  always @(posedge i_clk) begin
    cyc++;
    if (cyc >= MAX_CYC) begin
      $display("Run timed out after %0d cycles", cyc);
      print_report(1'b1);
    end
  end

  initial begin
    lfsr_state  = SEED;
    i_rst       = 1'b1;
    i_req_val   = '0;
    i_rsp_rdy   = '0;
    rsp_all_rdy = 1'b0;
    fair_win    = 1'b0;
    for (int c = 0; c < NUM_CLIENTS; c++) i_req[c] = '0;
    repeat (RST_CYC) @(posedge i_clk);
    #DRV_DLY;
    i_rst = 1'b0;
    // Edge pairs offered while the tables are still filling
    fork
      run_client(0, NUM_EDGE, MODE_EDGE);
      run_client(1, NUM_EDGE, MODE_EDGE);
    join
    // One client at a time
    run_client(0, NUM_SOLO, MODE_RAND);
    run_client(1, NUM_SOLO, MODE_RAND);
    // Both clients with gaps and back-pressure
    fork
      run_client(0, NUM_MIX, MODE_RAND);
      run_client(1, NUM_MIX, MODE_RAND);
    join
    // Both always valid, every output ready, grants counted in a window
    rsp_all_rdy = 1'b1;
    fork
      run_client(0, NUM_FAIR, MODE_FLOOD);
      run_client(1, NUM_FAIR, MODE_FLOOD);
      begin
        repeat (24) @(posedge i_clk);
        #DRV_DLY;
        fair_win = 1'b1;
        repeat (128) @(posedge i_clk);
        #DRV_DLY;
        fair_win = 1'b0;
      end
    join
    while (pend_cnt != 0) @(negedge i_clk);
    repeat (4) @(posedge i_clk);
    print_report(1'b0);
  end

endmodule

// ==== tb/mult_mod_checker.sv ====
`timescale 1ns/100ps

module mult_mod_checker
  import mm_pkg::*;
  import stream_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic [NUM_CLIENTS-1:0] i_req_val,
  input  op_t                    i_req [NUM_CLIENTS],
  input  logic [NUM_CLIENTS-1:0] i_req_rdy,
  input  logic [NUM_CLIENTS-1:0] i_rsp_val,
  input  res_t                   i_rsp [NUM_CLIENTS],
  input  logic [NUM_CLIENTS-1:0] i_rsp_rdy,
  input  logic                   i_fair_win,
  output int                     o_err_cnt,
  output int                     o_chk_cnt,
  output int                     o_pend_cnt
);

  // Table fill, then pipeline, then response FIFO before any result
  localparam int FIRST_RSP_MIN = TBL_DEPTH + PIPE_LAT + 1;

  op_t  exp_q [NUM_CLIENTS][$];
  int   win_cnt [NUM_CLIENTS];
  int   cyc_rel;
  logic seen_rsp;
  logic fair_d;

  // Reference model, a times b mod M in wide arithmetic
  function automatic res_t expect_mod_mul(input op_t op);
    logic [63:0] prod;
    prod = 64'(op.a) * 64'(op.b);
    return res_t'(prod % MODULUS);
  endfunction

  always @(posedge i_clk) begin
    op_t  op;
    res_t exp;
    int   lo;
    int   hi;
    if (i_rst) begin
      cyc_rel   = 0;
      seen_rsp  = 1'b0;
      fair_d    = 1'b0;
      o_err_cnt = 0;
      o_chk_cnt = 0;
      for (int c = 0; c < NUM_CLIENTS; c++) begin
        exp_q[c].delete();
        win_cnt[c] = 0;
      end
    end else begin
      // Responses first, so a same-edge request cannot hide an orphan result
      for (int c = 0; c < NUM_CLIENTS; c++) begin
        if (i_rsp_val[c] && !seen_rsp) begin
          seen_rsp = 1'b1;
          if (cyc_rel < FIRST_RSP_MIN) begin
            $display("First response at %0t came only %0d cycles after reset release",
                     $time, cyc_rel);
            o_err_cnt++;
          end
        end
        if (i_rsp_val[c] && i_rsp_rdy[c]) begin
          if (exp_q[c].size() == 0) begin
            $display("Client %0d got a result at %0t with no request outstanding", c, $time);
            o_err_cnt++;
          end else begin
            op  = exp_q[c].pop_front();
            exp = expect_mod_mul(op);
            o_chk_cnt++;
            if (i_rsp[c] !== exp) begin
              $display("[ERROR] %0t: client %0d a=%0d b=%0d expected %0d got %0d",
                       $time, c, op.a, op.b, exp, i_rsp[c]);
              o_err_cnt++;
            end
          end
        end
      end
      // Accepted requests, in client order
      for (int c = 0; c < NUM_CLIENTS; c++) begin
        if (i_req_val[c] && i_req_rdy[c]) begin
          exp_q[c].push_back(i_req[c]);
          if (i_fair_win) win_cnt[c]++;
        end
      end
      // Window closed, grant counts must stay within one
      if (fair_d && !i_fair_win) begin
        lo = win_cnt[0];
        hi = win_cnt[0];
        for (int c = 1; c < NUM_CLIENTS; c++) begin
          lo = (win_cnt[c] < lo) ? win_cnt[c] : lo;
          hi = (win_cnt[c] > hi) ? win_cnt[c] : hi;
        end
        if (lo == 0 || hi - lo > 1) begin
          $display("Unfair service in window ending at %0t, grants ranged %0d to %0d",
                   $time, lo, hi);
          o_err_cnt++;
        end
        for (int c = 0; c < NUM_CLIENTS; c++) win_cnt[c] = 0;
      end
      fair_d = i_fair_win;
      cyc_rel++;
    end
    o_pend_cnt = 0;
    for (int c = 0; c < NUM_CLIENTS; c++) o_pend_cnt += exp_q[c].size();
  end

endmodule

// ==== tb/mult_mod_asserts.sv ====
`timescale 1ns/100ps

module mult_mod_asserts
  import mm_pkg::*;
  import stream_pkg::*;
(
  input logic      i_clk,
  input logic      i_rst,
  input logic      i_in_rdy,
  input logic      i_out_val,
  input pipe_rsp_t i_out_rsp,
  input logic      i_out_rdy,
  input logic      i_tbl_built
);

  // Cycles since reset release, saturating once the fill is over
  int unsigned fill_cyc;
  // Number of assertion failures so far
  int          fail_cnt = 0;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      fill_cyc <= 0;
    end else if (fill_cyc < TBL_DEPTH) begin
      fill_cyc <= fill_cyc + 1;
    end
  end

  // Valid chain is cleared by reset
  a_val_reset : assert property (@(posedge i_clk) i_rst |=> !i_out_val)
    else begin
      $error("pipeline output valid high after a reset cycle");
      fail_cnt++;
    end

  // Stalled result holds until the response FIFO takes it
  a_out_hold : assert property (@(posedge i_clk) disable iff (i_rst)
    i_out_val && !i_out_rdy |=> i_out_val && $stable(i_out_rsp))
    else begin
      $error("pipeline output changed while stalled");
      fail_cnt++;
    end

  // Nothing enters during the table fill after reset
  a_no_early : assert property (@(posedge i_clk) disable iff (i_rst)
    fill_cyc < TBL_DEPTH |-> !i_tbl_built && !i_in_rdy)
    else begin
      $error("pipeline ready before tables built");
      fail_cnt++;
    end

endmodule

// ==== design/mult_mod_top.sv ====
`timescale 1ns/100ps

module mult_mod_top
  import stream_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst,
  // Client requests
  input  logic [NUM_CLIENTS-1:0] i_req_val,
  input  op_t                    i_req [NUM_CLIENTS],
  output logic [NUM_CLIENTS-1:0] o_req_rdy,
  // Client responses
  output logic [NUM_CLIENTS-1:0] o_rsp_val,
  output res_t                   o_rsp [NUM_CLIENTS],
  input  logic [NUM_CLIENTS-1:0] i_rsp_rdy
);

  // Request FIFO heads toward the arbiter
  logic [NUM_CLIENTS-1:0] reqf_val;
  op_t                    reqf_dat [NUM_CLIENTS];
  logic [NUM_CLIENTS-1:0] reqf_rdy;

  // Steered results toward the response FIFOs
  logic [NUM_CLIENTS-1:0] rspf_val;
  res_t                   rspf_dat [NUM_CLIENTS];
  logic [NUM_CLIENTS-1:0] rspf_rdy;

  // Arbiter and pipeline link
  logic      pipe_val;
  pipe_req_t pipe_req;
  logic      pipe_rdy;
  logic      res_val;
  pipe_rsp_t res;
  logic      res_rdy;

  for (genvar c = 0; c < NUM_CLIENTS; c++) begin : g_client
    stream_fifo #(.T(op_t), .DEPTH(FIFO_DEPTH)) u_req_fifo (
      .i_clk (i_clk),
      .i_rst (i_rst),
      .i_val (i_req_val[c]),
      .i_dat (i_req[c]),
      .o_rdy (o_req_rdy[c]),
      .o_val (reqf_val[c]),
      .o_dat (reqf_dat[c]),
      .i_rdy (reqf_rdy[c])
    );

    stream_fifo #(.T(res_t), .DEPTH(FIFO_DEPTH)) u_rsp_fifo (
      .i_clk (i_clk),
      .i_rst (i_rst),
      .i_val (rspf_val[c]),
      .i_dat (rspf_dat[c]),
      .o_rdy (rspf_rdy[c]),
      .o_val (o_rsp_val[c]),
      .o_dat (o_rsp[c]),
      .i_rdy (i_rsp_rdy[c])
    );
  end

  client_arbiter u_arb (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_req_val  (reqf_val),
    .i_req      (reqf_dat),
    .o_req_rdy  (reqf_rdy),
    .o_pipe_val (pipe_val),
    .o_pipe     (pipe_req),
    .i_pipe_rdy (pipe_rdy),
    .i_res_val  (res_val),
    .i_res      (res),
    .o_res_rdy  (res_rdy),
    .o_rsp_val  (rspf_val),
    .o_rsp      (rspf_dat),
    .i_rsp_rdy  (rspf_rdy)
  );

  mult_mod_pipe u_pipe (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_val (pipe_val),
    .i_req (pipe_req),
    .o_rdy (pipe_rdy),
    .o_val (res_val),
    .o_rsp (res),
    .i_rdy (res_rdy)
  );

endmodule

// ==== design/mult_mod_pipe.sv ====
`timescale 1ns/100ps

module mult_mod_pipe
  import mm_pkg::*;
  import stream_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  // Request side
  input  logic      i_val,
  input  pipe_req_t i_req,
  output logic      o_rdy,
  // Result side
  output logic      o_val,
  output pipe_rsp_t o_rsp,
  input  logic      i_rdy
);

  // Slices per operand in the partial-product grid
  localparam int NUM_SLC = DAT_BITS / GRID_BITS;
  localparam int SUM_W = DAT_BITS + 2;

  // Multiples of M for the final correction
  localparam logic [SUM_W-1:0] M1 = SUM_W'(MODULUS);
  localparam logic [SUM_W-1:0] M2 = SUM_W'(2 * MODULUS);
  localparam logic [SUM_W-1:0] M3 = SUM_W'(3 * MODULUS);

  logic [PIPE_LAT-1:0]            val;
  logic [PIPE_LAT-1:0][CID_W-1:0] cid;

  logic [DAT_BITS-1:0]    a_r;
  logic [DAT_BITS-1:0]    b_r;
  logic [2*GRID_BITS-1:0] pp [NUM_SLC][NUM_SLC];
  logic [2*DAT_BITS-1:0]  prod_c;
  logic [2*DAT_BITS-1:0]  prod_r;
  logic [DAT_BITS-1:0]    lo_r;
  res_t                   t24;
  res_t                   t16;
  logic                   built24;
  logic                   built16;
  logic                   tbl_built;
  logic [SUM_W-1:0]       sum_c;
  res_t                   res_c;
  res_t                   res_r;

  // Whole pipe moves only when the output can drain
  assign tbl_built = built24 && built16;
  assign o_rdy     = i_rdy && tbl_built;

  // Valid and client id ride alongside the datapath
  // An empty slot enters as client 0
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val <= '0;
      cid <= '0;
    end else if (i_rdy) begin
      val <= {val[PIPE_LAT-2:0], i_val && o_rdy};
      cid <= {cid[PIPE_LAT-2:0], i_val ? i_req.cid : CID_W'(0)};
    end
  end

  // Stage 1 operands, stage 2 grid, stage 3 product
  always_ff @(posedge i_clk) begin
    if (i_rdy) begin
      a_r <= i_req.op.a;
      b_r <= i_req.op.b;
      for (int i = 0; i < NUM_SLC; i++) begin
        for (int j = 0; j < NUM_SLC; j++) begin
          pp[i][j] <= a_r[i*GRID_BITS +: GRID_BITS] * b_r[j*GRID_BITS +: GRID_BITS];
        end
      end
      prod_r <= prod_c;
    end
  end

  // Shift each partial product to its grid position
  always_comb begin
    prod_c = '0;
    for (int i = 0; i < NUM_SLC; i++) begin
      for (int j = 0; j < NUM_SLC; j++) begin
        prod_c += (2 * DAT_BITS)'(pp[i][j]) << ((i + j) * GRID_BITS);
      end
    end
  end

  // Stage 4, top two bytes looked up while the low half waits
  reduce_table #(.SHIFT(3 * GRID_BITS)) u_tbl24 (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_en    (i_rdy),
    .i_addr  (prod_r[3*GRID_BITS +: GRID_BITS]),
    .o_dat   (t24),
    .o_built (built24)
  );

  reduce_table #(.SHIFT(2 * GRID_BITS)) u_tbl16 (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_en    (i_rdy),
    .i_addr  (prod_r[2*GRID_BITS +: GRID_BITS]),
    .o_dat   (t16),
    .o_built (built16)
  );

  always_ff @(posedge i_clk) begin
    if (i_rdy) begin
      lo_r <= prod_r[DAT_BITS-1:0];
    end
  end

  // Stage 5, sum stays below 4M so one correction is enough
  assign sum_c = SUM_W'(lo_r) + SUM_W'(t24) + SUM_W'(t16);

  always_comb begin
    if (sum_c >= M3) begin
      res_c = res_t'(sum_c - M3);
    end else if (sum_c >= M2) begin
      res_c = res_t'(sum_c - M2);
    end else if (sum_c >= M1) begin
      res_c = res_t'(sum_c - M1);
    end else begin
      res_c = res_t'(sum_c);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rdy) begin
      res_r <= res_c;
    end
  end

  assign o_val     = val[PIPE_LAT-1];
  assign o_rsp.cid = cid[PIPE_LAT-1];
  assign o_rsp.res = res_r;

endmodule

// ==== design/reduce_table.sv ====
`timescale 1ns/100ps

module reduce_table
  import mm_pkg::*;
  import stream_pkg::*;
#(
  parameter int SHIFT = 16
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_en,
  input  logic [TBL_AW-1:0] i_addr,
  output res_t              o_dat,
  output logic              o_built
);

  // Weight of one address step, 2^SHIFT mod M
  localparam longint unsigned STEP_L = (64'd1 << SHIFT) % MODULUS;
  localparam res_t STEP = res_t'(STEP_L);

  res_t mem [TBL_DEPTH];

  logic [TBL_AW-1:0]   fill_addr;
  res_t                fill_acc;
  logic [DAT_BITS:0]   fill_sum;
  logic                built;

  // Both terms are below M, so one subtraction brings the sum back
  assign fill_sum = {1'b0, fill_acc} + {1'b0, STEP};

  // Fill runs for TBL_DEPTH cycles straight after reset
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      fill_addr <= '0;
      fill_acc  <= '0;
      built     <= 1'b0;
    end else if (!built) begin
      fill_addr <= fill_addr + 1'b1;
      if (fill_sum >= (DAT_BITS + 1)'(MODULUS)) begin
        fill_acc <= res_t'(fill_sum - (DAT_BITS + 1)'(MODULUS));
      end else begin
        fill_acc <= res_t'(fill_sum);
      end
      // Last entry written, table is ready from next cycle
      if (fill_addr == TBL_AW'(TBL_DEPTH - 1)) begin
        built <= 1'b1;
      end
    end
  end

  // Entry k holds k * 2^SHIFT mod M
  always_ff @(posedge i_clk) begin
    if (!built) begin
      mem[fill_addr] <= fill_acc;
    end
  end

  // Registered read, holds while disabled
  always_ff @(posedge i_clk) begin
    if (i_en) begin
      o_dat <= mem[i_addr];
    end
  end

  assign o_built = built;

endmodule

// ==== design/client_arbiter.sv ====
`timescale 1ns/100ps

module client_arbiter
  import stream_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst,
  // Request FIFO heads
  input  logic [NUM_CLIENTS-1:0] i_req_val,
  input  op_t                    i_req [NUM_CLIENTS],
  output logic [NUM_CLIENTS-1:0] o_req_rdy,
  // Into the pipeline
  output logic                   o_pipe_val,
  output pipe_req_t              o_pipe,
  input  logic                   i_pipe_rdy,
  // Out of the pipeline
  input  logic                   i_res_val,
  input  pipe_rsp_t              i_res,
  output logic                   o_res_rdy,
  // Response FIFO inputs
  output logic [NUM_CLIENTS-1:0] o_rsp_val,
  output res_t                   o_rsp [NUM_CLIENTS],
  input  logic [NUM_CLIENTS-1:0] i_rsp_rdy
);

  logic             slot_val;
  pipe_req_t        slot;
  logic [CID_W-1:0] rr_ptr;
  logic [CID_W-1:0] win;
  logic             any_req;
  logic             load;

  // Round-robin search starting at rr_ptr
  // Walk backwards so the client nearest the pointer wins
  always_comb begin
    int idx;
    any_req = 1'b0;
    win     = rr_ptr;
    for (int k = NUM_CLIENTS - 1; k >= 0; k--) begin
      idx = (int'(rr_ptr) + k) % NUM_CLIENTS;
      if (i_req_val[idx]) begin
        any_req = 1'b1;
        win     = CID_W'(idx);
      end
    end
  end

  // Slot takes a new request when empty or draining this cycle
  assign load = any_req && (!slot_val || i_pipe_rdy);

  always_comb begin
    for (int c = 0; c < NUM_CLIENTS; c++) begin
      o_req_rdy[c] = load && (win == CID_W'(c));
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      slot_val <= 1'b0;
      rr_ptr   <= '0;
    end else if (load) begin
      slot_val <= 1'b1;
      // Pointer moves past the winner
      rr_ptr   <= (win == CID_W'(NUM_CLIENTS - 1)) ? '0 : win + 1'b1;
    end else if (i_pipe_rdy) begin
      slot_val <= 1'b0;
    end
  end

  // Granted payload with its client id
  always_ff @(posedge i_clk) begin
    if (load) begin
      slot.cid <= win;
      slot.op  <= i_req[win];
    end
  end

  assign o_pipe_val = slot_val;
  assign o_pipe     = slot;

  // Steer results by cid, back-pressure comes from that client only
  assign o_res_rdy = i_rsp_rdy[i_res.cid];

  always_comb begin
    for (int c = 0; c < NUM_CLIENTS; c++) begin
      o_rsp_val[c] = i_res_val && (i_res.cid == CID_W'(c));
      o_rsp[c]     = i_res.res;
    end
  end

endmodule

// ==== design/stream_fifo.sv ====
`timescale 1ns/100ps

module stream_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 4
) (
  input  logic i_clk,
  input  logic i_rst,
  // Write side
  input  logic i_val,
  input  T     i_dat,
  output logic o_rdy,
  // Read side
  output logic o_val,
  output T     o_dat,
  input  logic i_rdy
);

  // Pointer width stays at least one bit for a single-entry FIFO
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_wr;
  logic             do_rd;

  // Flags come from the registered count only
  assign o_rdy = (count != CNT_W'(DEPTH));
  assign o_val = (count != '0);
  assign o_dat = mem[rd_ptr];

  assign do_wr = i_val && o_rdy;
  assign do_rd = o_val && i_rdy;

  // Pointers wrap at DEPTH, so any depth works
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous read and write leaves the count unchanged
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge i_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= i_dat;
    end
  end

endmodule

// ==== design/stream_pkg.sv ====
// Client-side stream types shared by the arbiter, the pipeline and the top
package stream_pkg;

  import mm_pkg::*;

  // Number of clients sharing the pipeline
  localparam int NUM_CLIENTS = 2;

  // Width of the client id carried through the pipeline
  localparam int CID_W = 1;

  // Depth of each per-client request and response FIFO
  localparam int FIFO_DEPTH = 4;

  // Operand pair as offered by a client
  typedef struct packed {
    logic [DAT_BITS-1:0] a;
    logic [DAT_BITS-1:0] b;
  } op_t;

  // Reduced result, always below the modulus
  typedef logic [DAT_BITS-1:0] res_t;

  // Request into the shared pipeline, tagged with its client
  typedef struct packed {
    logic [CID_W-1:0] cid;
    op_t              op;
  } pipe_req_t;

  // Result out of the pipeline, still tagged for steering back
  typedef struct packed {
    logic [CID_W-1:0] cid;
    res_t             res;
  } pipe_rsp_t;

endpackage

// ==== design/mm_pkg.sv ====
// Arithmetic constants for the 16-bit modular multiplier
package mm_pkg;

  // Operand and result width
  localparam int DAT_BITS = 16;

  // Fixed prime modulus, largest prime below 2^16
  localparam int unsigned MODULUS = 65521;

  // Width of one partial-product slice in the multiplier grid
  localparam int GRID_BITS = 8;

  // Reduction table geometry, one entry per byte value
  localparam int TBL_DEPTH = 256;
  localparam int TBL_AW = $clog2(TBL_DEPTH);

  // Cycles from acceptance to result while the output is ready
  //   1 operand register
  //   2 partial products
  //   3 full product
  //   4 table lookups
  //   5 sum and final correction
  localparam int PIPE_LAT = 5;

endpackage
